//--- hw/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    // Machine information registers, read-only
    localparam logic [11:0] mvendorid_addr  = 12'hf11;
    localparam logic [11:0] marchid_addr    = 12'hf12;
    localparam logic [11:0] mimpid_addr     = 12'hf13;
    localparam logic [11:0] mhartid_addr    = 12'hf14;

    // Machine trap setup
    localparam logic [11:0] mstatus_addr    = 12'h300;
    localparam logic [11:0] misa_addr       = 12'h301;
    localparam logic [11:0] mie_addr        = 12'h304;
    localparam logic [11:0] mtvec_addr      = 12'h305;
    localparam logic [11:0] mcounteren_addr = 12'h306;

    // Machine trap handling
    localparam logic [11:0] mscratch_addr   = 12'h340;
    localparam logic [11:0] mepc_addr       = 12'h341;
    localparam logic [11:0] mcause_addr     = 12'h342;
    localparam logic [11:0] mtval_addr      = 12'h343;
    localparam logic [11:0] mip_addr        = 12'h344;

    // The core only ever runs in M-mode
    localparam logic [1:0] machine_mode = 2'b11;

    localparam int num_trap_regs = 4;

    localparam int trap_idx_mscratch = 0;
    localparam int trap_idx_mepc     = 1;
    localparam int trap_idx_mcause   = 2;
    localparam int trap_idx_mtval    = 3;

    // Address of each slot in the trap register array
    localparam logic [11:0] trap_reg_addr [num_trap_regs] = '{
        trap_idx_mscratch: mscratch_addr,
        trap_idx_mepc:     mepc_addr,
        trap_idx_mcause:   mcause_addr,
        trap_idx_mtval:    mtval_addr
    };

endpackage

`default_nettype wire

//--- hw/csr_fields_pkg.sv
`default_nettype none

package csr_fields_pkg;

    import csr_map_pkg::*;

    // mstatus layout as seen by an M-only hart
    typedef struct packed {
        logic [18:0] wpri_31_13;
        logic [1:0]  mpp;
        logic [2:0]  wpri_10_8;
        logic        mpie;
        logic [2:0]  wpri_6_4;
        logic        mie;
        logic [2:0]  wpri_2_0;
    } mstatus_fields_t;

    // One CSR data word, either raw or split into mstatus fields
    typedef union packed {
        logic [31:0]     raw;
        mstatus_fields_t fields;
    } csr_word_u;

    // MIE and MPIE
    localparam logic [31:0] mstatus_wmask = 32'h0000_0088;

    // Software, timer and external interrupt bits
    localparam logic [31:0] irq_wmask = 32'h0000_0888;

    // Reset values of mscratch, mepc, mcause and mtval
    localparam logic [31:0] trap_reset_val [num_trap_regs] = '{
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000
    };

    // RV32I, MXL = 1
    localparam logic [31:0] misa_val = 32'h4000_0100;

endpackage

`default_nettype wire

//--- hw/csr_write_decode.sv
`timescale 1ns/1ns
`default_nettype none

module csr_write_decode
    import csr_map_pkg::*;
(
    input  logic                     wr_csr_n,
    input  logic [11:0]              csr_wr_addr,
    output logic                     wr_mstatus,
    output logic                     wr_mie,
    output logic                     wr_mip,
    output logic [num_trap_regs-1:0] wr_trap
);

    logic wr_csr;

    // Strobe from the pipeline is active low
    assign wr_csr = !wr_csr_n;

    // Status and interrupt registers
    assign wr_mstatus = wr_csr && (csr_wr_addr == mstatus_addr);
    assign wr_mie     = wr_csr && (csr_wr_addr == mie_addr);
    assign wr_mip     = wr_csr && (csr_wr_addr == mip_addr);

    // One enable per trap register slot
    genvar i;
    generate
        for (i = 0; i < num_trap_regs; i++)
        begin : g_trap_wr
            assign wr_trap[i] = wr_csr && (csr_wr_addr == trap_reg_addr[i]);
        end
    endgenerate

    // Read-only and unknown addresses fall through with no enable set

endmodule

`default_nettype wire

//--- hw/csr_trap_reg.sv
`timescale 1ns/1ns
`default_nettype none

module csr_trap_reg
    import csr_fields_pkg::*;
#(
    parameter logic [31:0] reset_val = 32'h0000_0000
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_reg,
    input  csr_word_u   data_in,
    output logic [31:0] value
);

    // Full 32-bit word, no field masking on trap registers
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            value <= reset_val;
        end
        else if (wr_reg)
        begin
            value <= data_in.raw;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_status_regs.sv
`timescale 1ns/1ns
`default_nettype none

module csr_status_regs
    import csr_map_pkg::*;
    import csr_fields_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        is_mret,
    input  logic        wr_mstatus,
    input  logic        wr_mie,
    input  logic        wr_mip,
    input  csr_word_u   data_in,
    output csr_word_u   mstatus,
    output logic [31:0] mie,
    output logic [31:0] mip,
    output logic        irq_pending
);

    logic      status_mie;
    logic      status_mpie;
    csr_word_u wr_word;

    // Keep only the writable mstatus bits
    assign wr_word.raw = data_in.raw & mstatus_wmask;

    // MRET takes priority over a software write
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end
        else if (is_mret)
        begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end
        else if (wr_mstatus)
        begin
            status_mie  <= wr_word.fields.mie;
            status_mpie <= wr_word.fields.mpie;
        end
    end

    // MPP is hardwired, no lower modes to return to
    always_comb
    begin
        mstatus.raw         = 32'h0000_0000;
        mstatus.fields.mpp  = machine_mode;
        mstatus.fields.mpie = status_mpie;
        mstatus.fields.mie  = status_mie;
    end

    // Interrupt enable and pending, software written only
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mie <= 32'h0000_0000;
            mip <= 32'h0000_0000;
        end
        else
        begin
            if (wr_mie)
                mie <= data_in.raw & irq_wmask;
            if (wr_mip)
                mip <= data_in.raw & irq_wmask;
        end
    end

    // Global enable plus at least one enabled pending source
    assign irq_pending = status_mie && |(mie & mip);

endmodule

`default_nettype wire

//--- hw/csr_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux
    import csr_map_pkg::*;
    import csr_fields_pkg::*;
#(
    parameter logic [31:0] hart_id    = 32'h0000_0000,
    parameter logic [31:0] mtvec_base = 32'h0000_0000
)
(
    input  logic [11:0]                   csr_addr,
    input  csr_word_u                     mstatus,
    input  logic [31:0]                   mie,
    input  logic [31:0]                   mip,
    input  logic [num_trap_regs-1:0][31:0] trap_vals,
    output csr_word_u                     csr_out
);

    always_comb
    begin
        case (csr_addr)
            // Info registers not implemented, read as zero
            mvendorid_addr:  csr_out.raw = 32'h0000_0000;
            marchid_addr:    csr_out.raw = 32'h0000_0000;
            mimpid_addr:     csr_out.raw = 32'h0000_0000;
            mhartid_addr:    csr_out.raw = hart_id;

            mstatus_addr:    csr_out     = mstatus;
            misa_addr:       csr_out.raw = misa_val;
            mie_addr:        csr_out.raw = mie;
            mtvec_addr:      csr_out.raw = mtvec_base;
            mcounteren_addr: csr_out.raw = 32'h0000_0000;
            mip_addr:        csr_out.raw = mip;

            default:
            begin
                // Trap registers, otherwise zero for unknown addresses
                csr_out.raw = 32'h0000_0000;
                for (int i = 0; i < num_trap_regs; i++)
                begin
                    if (csr_addr == trap_reg_addr[i])
                        csr_out.raw = trap_vals[i];
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file
    import csr_map_pkg::*;
    import csr_fields_pkg::*;
#(
    parameter logic [31:0] hart_id    = 32'h0000_0000,
    parameter logic [31:0] mtvec_base = 32'h0000_0000
)
(
    input  logic        clk,
    input  logic        rst_n,
    // Read port
    input  logic [11:0] csr_addr,
    // Write port
    input  logic [11:0] csr_wr_addr,
    input  csr_word_u   csr_data_in,
    input  logic        wr_csr_n,
    // One-cycle pulse on MRET
    input  logic        is_mret,
    output csr_word_u   csr_out,
    output logic        irq_pending
);

    logic                           wr_mstatus;
    logic                           wr_mie;
    logic                           wr_mip;
    logic [num_trap_regs-1:0]       wr_trap;
    csr_word_u                      mstatus;
    logic [31:0]                    mie;
    logic [31:0]                    mip;
    logic [num_trap_regs-1:0][31:0] trap_vals;

    csr_write_decode i_write_decode (
        .wr_csr_n    (wr_csr_n),
        .csr_wr_addr (csr_wr_addr),
        .wr_mstatus  (wr_mstatus),
        .wr_mie      (wr_mie),
        .wr_mip      (wr_mip),
        .wr_trap     (wr_trap)
    );

    csr_status_regs i_status_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .is_mret     (is_mret),
        .wr_mstatus  (wr_mstatus),
        .wr_mie      (wr_mie),
        .wr_mip      (wr_mip),
        .data_in     (csr_data_in),
        .mstatus     (mstatus),
        .mie         (mie),
        .mip         (mip),
        .irq_pending (irq_pending)
    );

    // mscratch, mepc, mcause, mtval
    genvar i;
    generate
        for (i = 0; i < num_trap_regs; i++)
        begin : g_trap_reg
            csr_trap_reg #(
                .reset_val (trap_reset_val[i])
            ) i_trap_reg (
                .clk     (clk),
                .rst_n   (rst_n),
                .wr_reg  (wr_trap[i]),
                .data_in (csr_data_in),
                .value   (trap_vals[i])
            );
        end
    endgenerate

    csr_read_mux #(
        .hart_id    (hart_id),
        .mtvec_base (mtvec_base)
    ) i_read_mux (
        .csr_addr  (csr_addr),
        .mstatus   (mstatus),
        .mie       (mie),
        .mip       (mip),
        .trap_vals (trap_vals),
        .csr_out   (csr_out)
    );

endmodule

`default_nettype wire

//--- tests/csr_file_checker.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file_checker
    import csr_map_pkg::*;
    import csr_fields_pkg::*;
(
    input logic                           clk,
    input logic                           rst_n,
    input logic                           is_mret,
    input logic                           wr_csr_n,
    input logic [11:0]                    csr_wr_addr,
    input csr_word_u                      mstatus,
    input logic [31:0]                    mie,
    input logic [31:0]                    mip,
    input logic [num_trap_regs-1:0][31:0] trap_vals,
    input logic                           irq_pending
);

    int   fail_count = 0;
    logic ro_write;

    // Write strobe aimed at a read-only register
    assign ro_write = !wr_csr_n && !is_mret &&
        (csr_wr_addr inside {mvendorid_addr, marchid_addr, mimpid_addr, mhartid_addr,
                             misa_addr, mtvec_addr, mcounteren_addr});

    // MIE takes the old MPIE and MPIE goes high
    a_mret_update: assert property (@(posedge clk) disable iff (!rst_n)
        is_mret |=> (mstatus.fields.mie == $past(mstatus.fields.mpie)) && mstatus.fields.mpie)
    else
    begin
        $error("MRET did not restore MIE from MPIE or did not set MPIE");
        fail_count++;
    end

    a_irq_pending: assert property (@(posedge clk) disable iff (!rst_n)
        irq_pending == (mstatus.fields.mie && (|(mie & mip))))
    else
    begin
        $error("irq_pending does not match MIE and the mie and mip bits");
        fail_count++;
    end

    a_mpp_fixed: assert property (@(posedge clk) disable iff (!rst_n)
        mstatus.fields.mpp == machine_mode)
    else
    begin
        $error("MPP is not machine mode");
        fail_count++;
    end

    a_ro_write: assert property (@(posedge clk) disable iff (!rst_n)
        ro_write |=> $stable(mstatus.raw) && $stable(mie) && $stable(mip) && $stable(trap_vals))
    else
    begin
        $error("write to a read-only address changed a register");
        fail_count++;
    end

endmodule

bind csr_file csr_file_checker i_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_mret     (is_mret),
    .wr_csr_n    (wr_csr_n),
    .csr_wr_addr (csr_wr_addr),
    .mstatus     (mstatus),
    .mie         (mie),
    .mip         (mip),
    .trap_vals   (trap_vals),
    .irq_pending (irq_pending)
);

`default_nettype wire

//--- tests/csr_file_tb.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file_tb
    import csr_map_pkg::*;
    import csr_fields_pkg::*;
();

    localparam int clk_period = 10;

    logic        clk;
    logic        rst_n;
    logic [11:0] csr_addr;
    logic [11:0] csr_wr_addr;
    csr_word_u   csr_data_in;
    logic        wr_csr_n;
    logic        is_mret;
    csr_word_u   csr_out;
    logic        irq_pending;

    integer seed;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     assert_fails;
    string  test_name;

    csr_file #(
        .hart_id    (32'h0000_0003),
        .mtvec_base (32'h0000_0100)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_wr_addr (csr_wr_addr),
        .csr_data_in (csr_data_in),
        .wr_csr_n    (wr_csr_n),
        .is_mret     (is_mret),
        .csr_out     (csr_out),
        .irq_pending (irq_pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Each edge is awaited with its own timeout, then step to the drive point
    task wait_cycles(input int n);
        for (int k = 0; k < n; k++)
        begin
            fork
                @(posedge clk);
                begin
                    #(4 * clk_period);
                    $display("Timeout: no rising clock edge within %0d ns", 4 * clk_period);
                    $display("STATUS: FAIL");
                    $finish;
                end
            join_any
            disable fork;
        end
        #1;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        csr_wr_addr     = addr;
        csr_data_in.raw = data;
        wr_csr_n        = 1'b0;
        wait_cycles(1);
        wr_csr_n        = 1'b1;
    endtask

    task automatic do_mret();
        is_mret = 1'b1;
        wait_cycles(1);
        is_mret = 1'b0;
    endtask

    task automatic check_word(input csr_word_u expected, input csr_word_u actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %08h, actual %08h",
                     test_name, expected.raw, actual.raw);
            errors++;
        end
    endtask

    task automatic check_irq(input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected irq_pending %b, actual %b",
                     test_name, expected, actual);
            errors++;
        end
    endtask

    // Read one CSR mid-cycle and compare, uses up one cycle
    task automatic expect_csr(input logic [11:0] addr, input logic [31:0] value);
        csr_word_u expected;
        expected.raw = value;
        csr_addr     = addr;
        #1;
        check_word(expected, csr_out);
        wait_cycles(1);
    endtask

    task automatic write_and_check_irq(input logic [11:0] addr, input logic [31:0] data,
                                       input logic expected);
        write_csr(addr, data);
        check_irq(expected, irq_pending);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic close_test();
        if (errors != test_errors)
            tests_failed++;
        $display("Test %s finished with %0d mismatches", test_name, errors - test_errors);
    endtask

    task automatic reset_values_test();
        start_test("reset_values");
        expect_csr(mstatus_addr, 32'h0000_1800);
        expect_csr(mie_addr, 32'h0);
        expect_csr(mip_addr, 32'h0);
        for (int i = 0; i < 4; i++)
            expect_csr(trap_reg_addr[i], 32'h0);
        check_irq(1'b0, irq_pending);
        close_test();
    endtask

    task automatic trap_regs_test();
        logic [31:0] data [4];
        csr_word_u   old_word;
        start_test("trap_regs");
        for (int i = 0; i < 4; i++)
        begin
            data[i] = $random(seed);
            write_csr(trap_reg_addr[i], data[i]);
        end
        for (int i = 0; i < 4; i++)
            expect_csr(trap_reg_addr[i], data[i]);
        // Same-cycle read still returns the previous contents
        old_word.raw    = data[0];
        csr_addr        = mscratch_addr;
        csr_wr_addr     = mscratch_addr;
        csr_data_in.raw = ~data[0];
        wr_csr_n        = 1'b0;
        #1;
        check_word(old_word, csr_out);
        wait_cycles(1);
        wr_csr_n = 1'b1;
        expect_csr(mscratch_addr, ~data[0]);
        close_test();
    endtask

    task automatic read_only_test();
        logic [11:0] ro_addr [7];
        logic [31:0] ro_val [7];
        ro_addr = '{mvendorid_addr, marchid_addr, mimpid_addr, mhartid_addr,
                    misa_addr, mtvec_addr, mcounteren_addr};
        ro_val  = '{32'h0, 32'h0, 32'h0, 32'h3, 32'h4000_0100, 32'h0000_0100, 32'h0};
        start_test("read_only");
        for (int i = 0; i < 7; i++)
        begin
            expect_csr(ro_addr[i], ro_val[i]);
            write_csr(ro_addr[i], 32'hffff_ffff);
            expect_csr(ro_addr[i], ro_val[i]);
        end
        write_csr(12'h7c0, 32'hffff_ffff);
        expect_csr(12'h7c0, 32'h0);
        expect_csr(mstatus_addr, 32'h0000_1800);
        expect_csr(mie_addr, 32'h0);
        expect_csr(mip_addr, 32'h0);
        close_test();
    endtask

    task automatic write_masks_test();
        start_test("write_masks");
        write_csr(mstatus_addr, 32'hffff_ffff);
        expect_csr(mstatus_addr, 32'h0000_1888);
        write_csr(mie_addr, 32'hffff_ffff);
        expect_csr(mie_addr, 32'h0000_0888);
        write_csr(mip_addr, 32'hffff_ffff);
        expect_csr(mip_addr, 32'h0000_0888);
        write_csr(mstatus_addr, 32'h0);
        write_csr(mie_addr, 32'h0);
        write_csr(mip_addr, 32'h0);
        close_test();
    endtask

    task automatic irq_test();
        start_test("irq_pending");
        write_and_check_irq(mie_addr, 32'h0000_0080, 1'b0);
        write_and_check_irq(mip_addr, 32'h0000_0080, 1'b0);
        write_and_check_irq(mstatus_addr, 32'h0000_0008, 1'b1);
        write_and_check_irq(mstatus_addr, 32'h0, 1'b0);
        write_and_check_irq(mstatus_addr, 32'h0000_0008, 1'b1);
        write_and_check_irq(mip_addr, 32'h0, 1'b0);
        // Pending bit without a matching enable
        write_and_check_irq(mip_addr, 32'h0000_0800, 1'b0);
        write_and_check_irq(mip_addr, 32'h0000_0880, 1'b1);
        write_and_check_irq(mie_addr, 32'h0, 1'b0);
        write_csr(mip_addr, 32'h0);
        close_test();
    endtask

    task automatic mret_test();
        start_test("mret");
        write_csr(mstatus_addr, 32'h0000_0080);
        expect_csr(mstatus_addr, 32'h0000_1880);
        do_mret();
        expect_csr(mstatus_addr, 32'h0000_1888);
        write_csr(mstatus_addr, 32'h0000_0008);
        do_mret();
        expect_csr(mstatus_addr, 32'h0000_1880);
        // Write of MIE=1, MPIE=0 in the MRET cycle loses to MRET
        csr_wr_addr     = mstatus_addr;
        csr_data_in.raw = 32'h0000_0008;
        wr_csr_n        = 1'b0;
        is_mret         = 1'b1;
        wait_cycles(1);
        wr_csr_n = 1'b1;
        is_mret  = 1'b0;
        expect_csr(mstatus_addr, 32'h0000_1888);
        close_test();
    endtask

    initial
    begin
        seed            = 32'hac63;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        rst_n           = 1'b0;
        csr_addr        = 12'h0;
        csr_wr_addr     = 12'h0;
        csr_data_in.raw = 32'h0;
        wr_csr_n        = 1'b1;
        is_mret         = 1'b0;
        wait_cycles(16);
        rst_n = 1'b1;

        reset_values_test();
        trap_regs_test();
        read_only_test();
        write_masks_test();
        irq_test();
        mret_test();

        assert_fails = i_dut.i_checker.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hw/csr_map_pkg.sv
hw/csr_fields_pkg.sv
hw/csr_write_decode.sv
hw/csr_trap_reg.sv
hw/csr_status_regs.sv
hw/csr_read_mux.sv
hw/csr_file.sv
tests/csr_file_checker.sv
tests/csr_file_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = csr_file_tb
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
RUN_ARGS   = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
